// File: source/core_pkg.sv
package core_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;
  localparam int reg_addr_w = 5;

  localparam int iq_depth = 4;
  localparam int iq_ptr_w = $clog2(iq_depth);
  localparam int iq_cnt_w = $clog2(iq_depth + 1);

  localparam int rs_depth = 4;
  localparam int rs_ptr_w = $clog2(rs_depth);
  localparam int rs_cnt_w = $clog2(rs_depth + 1);

  localparam int pend_w = 4;  // outstanding writes per register, max in flight is well below 16

  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_opimm = 7'b0010011;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_func_e;

  typedef struct packed {
    logic valid_op;  // OP or OP-IMM
    alu_func_e func;
    logic use_imm;
    logic [xlen-1:0] imm;  // I-immediate, sign extended
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
  } decoded_t;

  // four-phase sender and receiver sides
  typedef enum logic [1:0] {tx_idle, tx_req, tx_release} tx_state_e;
  typedef enum logic {rx_idle, rx_acked} rx_state_e;

  typedef enum logic [1:0] {alu_idle, alu_calc, alu_offer, alu_release} alu_state_e;

endpackage

// File: source/stage_if.sv
// issue unit to reservation station
interface issue_if import core_pkg::*; ();
  logic req;
  logic ack;
  alu_func_e func;
  logic [xlen-1:0] rval1;
  logic [xlen-1:0] rval2;  // already muxed with the immediate
  logic [reg_addr_w-1:0] rd;

  modport sender (output req, func, rval1, rval2, rd, input ack);
  modport receiver (input req, func, rval1, rval2, rd, output ack);
endinterface

// reservation station to ALU
interface exec_if import core_pkg::*; ();
  logic req;
  logic ack;
  alu_func_e func;
  logic [xlen-1:0] rval1;
  logic [xlen-1:0] rval2;
  logic [reg_addr_w-1:0] rd;

  modport sender (output req, func, rval1, rval2, rd, input ack);
  modport receiver (input req, func, rval1, rval2, rd, output ack);
endinterface

// File: source/instruction_queue.sv
module instruction_queue import core_pkg::*; (
  input  logic            clk_100mhz,
  input  logic            rst,
  input  logic            inst_req,
  input  logic [xlen-1:0] instruction,
  input  logic            pop,
  output logic            inst_ack,
  output logic [xlen-1:0] head,
  output logic            head_valid
);

  logic [xlen-1:0] mem [iq_depth];
  logic [iq_ptr_w-1:0] wr_ptr;
  logic [iq_ptr_w-1:0] rd_ptr;
  logic [iq_cnt_w-1:0] count;
  rx_state_e state;
  logic full;
  logic push;
  logic pop_ok;

  assign full = count == iq_cnt_w'(iq_depth);
  assign push = state == rx_idle && inst_req && !full;  // one write per req
  assign pop_ok = pop && head_valid;

  assign inst_ack = state == rx_acked;
  assign head = mem[rd_ptr];
  assign head_valid = count != '0;

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      state <= rx_idle;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      case (state)
        rx_idle: if (push) state <= rx_acked;
        rx_acked: if (!inst_req) state <= rx_idle;  // sender released, drop ack
        default: state <= rx_idle;
      endcase
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
      count <= count + iq_cnt_w'(push) - iq_cnt_w'(pop_ok);
    end
  end

  // storage
  always_ff @(posedge clk_100mhz) begin
    if (push) mem[wr_ptr] <= instruction;
  end

endmodule

// File: source/decoder.sv
module decoder import core_pkg::*; (
  input  logic [xlen-1:0] instruction,
  output decoded_t        decoded
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic alt;  // funct7 bit 5, selects sub and sra

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign alt = instruction[30];

  always_comb begin
    decoded.valid_op = (opcode == opcode_op) || (opcode == opcode_opimm);
    decoded.use_imm = opcode == opcode_opimm;
    decoded.imm = {{20{instruction[31]}}, instruction[31:20]};
    decoded.rs1 = instruction[19:15];
    decoded.rs2 = instruction[24:20];
    decoded.rd = instruction[11:7];

    case (funct3)
      3'b000: begin
        // addi has no sub form, bit 30 is just immediate there
        decoded.func = (alt && !decoded.use_imm) ? alu_sub : alu_add;
      end
      3'b001: decoded.func = alu_sll;
      3'b010: decoded.func = alu_slt;
      3'b011: decoded.func = alu_sltu;
      3'b100: decoded.func = alu_xor;
      3'b101: decoded.func = alt ? alu_sra : alu_srl;  // srai too
      3'b110: decoded.func = alu_or;
      default: decoded.func = alu_and;
    endcase
  end

endmodule

// File: source/register_file.sv
module register_file import core_pkg::*; (
  input  logic                  clk_100mhz,
  input  logic                  rst,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic                  set_busy,
  input  logic [reg_addr_w-1:0] busy_addr,
  input  logic                  wb_en,
  input  logic [reg_addr_w-1:0] wb_addr,
  input  logic [xlen-1:0]       wb_data,
  output logic [xlen-1:0]       rdata1,
  output logic [xlen-1:0]       rdata2,
  output logic                  busy1,
  output logic                  busy2
);

  logic [xlen-1:0] regs [reg_count];
  // busy is a count of pending writers so two in-flight writes to one rd keep it busy
  logic [pend_w-1:0] pend [reg_count];
  logic wb_hit1;
  logic wb_hit2;

  assign wb_hit1 = wb_en && wb_addr == rs1 && rs1 != '0;
  assign wb_hit2 = wb_en && wb_addr == rs2 && rs2 != '0;

  // x0 reads zero; same-cycle writeback bypassed
  assign rdata1 = (rs1 == '0) ? '0 : (wb_hit1 ? wb_data : regs[rs1]);
  assign rdata2 = (rs2 == '0) ? '0 : (wb_hit2 ? wb_data : regs[rs2]);

  // last writer retiring this cycle frees the source
  assign busy1 = pend[rs1] != '0 && !(wb_hit1 && pend[rs1] == pend_w'(1));
  assign busy2 = pend[rs2] != '0 && !(wb_hit2 && pend[rs2] == pend_w'(1));

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
        pend[i] <= '0;
      end
    end else begin
      if (wb_en && wb_addr != '0) regs[wb_addr] <= wb_data;
      for (int i = 1; i < reg_count; i++) begin
        pend[i] <= pend[i]
                 + pend_w'(set_busy && busy_addr == reg_addr_w'(i))
                 - pend_w'(wb_en && wb_addr == reg_addr_w'(i));
      end
    end
  end

endmodule

// File: source/issue_unit.sv
module issue_unit import core_pkg::*; (
  input  logic                  clk_100mhz,
  input  logic                  rst,
  input  logic [xlen-1:0]       head,
  input  logic                  head_valid,
  input  logic [xlen-1:0]       rdata1,
  input  logic [xlen-1:0]       rdata2,
  input  logic                  busy1,
  input  logic                  busy2,
  output logic                  pop,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output logic                  set_busy,
  output logic [reg_addr_w-1:0] busy_addr,
  issue_if.sender               issue
);

  decoded_t dec;
  tx_state_e state;
  logic hazard;
  logic go;

  decoder decoder_i (
    .instruction(head),
    .decoded(dec)
  );

  assign rs1 = dec.rs1;
  assign rs2 = dec.rs2;
  assign busy_addr = dec.rd;

  // rs2 field is immediate bits for OP-IMM
  assign hazard = busy1 || (busy2 && !dec.use_imm);
  // idle implies ack already low
  assign go = head_valid && dec.valid_op && !hazard && state == tx_idle;

  assign set_busy = go;
  assign pop = go || (head_valid && !dec.valid_op);  // other opcodes just vanish

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      state <= tx_idle;
      issue.req <= 1'b0;
    end else begin
      case (state)
        tx_idle: begin
          if (go) begin
            issue.req <= 1'b1;
            state <= tx_req;
          end
        end
        tx_req: begin
          if (issue.ack) begin
            issue.req <= 1'b0;
            state <= tx_release;
          end
        end
        tx_release: if (!issue.ack) state <= tx_idle;
        default: state <= tx_idle;
      endcase
    end
  end

  // operands held while req is up
  always_ff @(posedge clk_100mhz) begin
    if (go) begin
      issue.func <= dec.func;
      issue.rval1 <= rdata1;
      issue.rval2 <= dec.use_imm ? dec.imm : rdata2;
      issue.rd <= dec.rd;
    end
  end

endmodule

// File: source/reservation_station.sv
module reservation_station import core_pkg::*; (
  input  logic        clk_100mhz,
  input  logic        rst,
  issue_if.receiver   issue,
  exec_if.sender      exec
);

  alu_func_e ent_func [rs_depth];
  logic [xlen-1:0] ent_rval1 [rs_depth];
  logic [xlen-1:0] ent_rval2 [rs_depth];
  logic [reg_addr_w-1:0] ent_rd [rs_depth];

  logic [rs_ptr_w-1:0] wr_ptr;
  logic [rs_ptr_w-1:0] rd_ptr;
  logic [rs_cnt_w-1:0] count;
  rx_state_e in_state;
  tx_state_e out_state;
  logic push;
  logic retire;

  assign push = in_state == rx_idle && issue.req && count != rs_cnt_w'(rs_depth);
  assign retire = out_state == tx_req && exec.ack;  // entry leaves once the ALU has it

  assign issue.ack = in_state == rx_acked;

  // oldest entry, pointer only moves after req drops
  assign exec.func = ent_func[rd_ptr];
  assign exec.rval1 = ent_rval1[rd_ptr];
  assign exec.rval2 = ent_rval2[rd_ptr];
  assign exec.rd = ent_rd[rd_ptr];

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      in_state <= rx_idle;
      out_state <= tx_idle;
      exec.req <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      case (in_state)
        rx_idle: if (push) in_state <= rx_acked;
        rx_acked: if (!issue.req) in_state <= rx_idle;
        default: in_state <= rx_idle;
      endcase

      case (out_state)
        tx_idle: begin
          if (count != '0) begin
            exec.req <= 1'b1;
            out_state <= tx_req;
          end
        end
        tx_req: begin
          if (exec.ack) begin
            exec.req <= 1'b0;
            out_state <= tx_release;
          end
        end
        tx_release: if (!exec.ack) out_state <= tx_idle;
        default: out_state <= tx_idle;
      endcase

      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (retire) rd_ptr <= rd_ptr + 1'b1;
      count <= count + rs_cnt_w'(push) - rs_cnt_w'(retire);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (push) begin
      ent_func[wr_ptr] <= issue.func;
      ent_rval1[wr_ptr] <= issue.rval1;
      ent_rval2[wr_ptr] <= issue.rval2;
      ent_rd[wr_ptr] <= issue.rd;
    end
  end

endmodule

// File: source/alu.sv
module alu import core_pkg::*; (
  input  logic                  clk_100mhz,
  input  logic                  rst,
  input  logic                  result_ack,
  exec_if.receiver              exec,
  output logic                  result_req,
  output logic [xlen-1:0]       result_data,
  output logic [reg_addr_w-1:0] result_rd,
  output logic                  wb_en,
  output logic [reg_addr_w-1:0] wb_addr,
  output logic [xlen-1:0]       wb_data
);

  alu_func_e op_func;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [reg_addr_w-1:0] op_rd;
  logic [4:0] shamt;
  logic [xlen-1:0] calc;
  alu_state_e state;
  rx_state_e rx_state;
  logic take;

  assign exec.ack = rx_state == rx_acked;
  assign take = state == alu_idle && rx_state == rx_idle && exec.req;
  assign shamt = op_b[4:0];

  always_comb begin
    case (op_func)
      alu_add:  calc = op_a + op_b;
      alu_sub:  calc = op_a - op_b;
      alu_sll:  calc = op_a << shamt;
      alu_slt:  calc = xlen'($signed(op_a) < $signed(op_b));
      alu_sltu: calc = xlen'(op_a < op_b);
      alu_xor:  calc = op_a ^ op_b;
      alu_srl:  calc = op_a >> shamt;
      alu_sra:  calc = $signed(op_a) >>> shamt;
      alu_or:   calc = op_a | op_b;
      default:  calc = op_a & op_b;
    endcase
  end

  assign wb_addr = result_rd;
  assign wb_data = result_data;

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      state <= alu_idle;
      rx_state <= rx_idle;
      result_req <= 1'b0;
      wb_en <= 1'b0;
    end else begin
      wb_en <= 1'b0;  // single-cycle pulse
      if (take) rx_state <= rx_acked;
      else if (rx_state == rx_acked && !exec.req) rx_state <= rx_idle;

      case (state)
        alu_idle: if (take) state <= alu_calc;
        alu_calc: begin
          result_req <= 1'b1;
          state <= alu_offer;
        end
        alu_offer: begin
          if (result_ack) begin
            result_req <= 1'b0;
            wb_en <= 1'b1;  // frees rd in the scoreboard
            state <= alu_release;
          end
        end
        default: if (!result_ack) state <= alu_idle;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (take) begin
      op_func <= exec.func;
      op_a <= exec.rval1;
      op_b <= exec.rval2;
      op_rd <= exec.rd;
    end
    if (state == alu_calc) begin
      result_data <= calc;
      result_rd <= op_rd;
    end
  end

endmodule

// File: source/core_top.sv
module core_top import core_pkg::*; (
  input  logic                  clk_100mhz,
  input  logic                  rst,
  input  logic                  inst_req,
  input  logic [xlen-1:0]       instruction,
  input  logic                  result_ack,
  output logic                  inst_ack,
  output logic                  result_req,
  output logic [xlen-1:0]       result_data,
  output logic [reg_addr_w-1:0] result_rd
);

  logic [xlen-1:0] head;
  logic head_valid;
  logic pop;

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic busy1;
  logic busy2;
  logic set_busy;
  logic [reg_addr_w-1:0] busy_addr;

  logic wb_en;
  logic [reg_addr_w-1:0] wb_addr;
  logic [xlen-1:0] wb_data;

  issue_if issue_bus ();
  exec_if exec_bus ();

  instruction_queue instruction_queue_i (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .inst_req(inst_req),
    .instruction(instruction),
    .pop(pop),
    .inst_ack(inst_ack),
    .head(head),
    .head_valid(head_valid)
  );

  register_file register_file_i (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .rs1(rs1),
    .rs2(rs2),
    .set_busy(set_busy),
    .busy_addr(busy_addr),
    .wb_en(wb_en),
    .wb_addr(wb_addr),
    .wb_data(wb_data),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .busy1(busy1),
    .busy2(busy2)
  );

  issue_unit issue_unit_i (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .head(head),
    .head_valid(head_valid),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .busy1(busy1),
    .busy2(busy2),
    .pop(pop),
    .rs1(rs1),
    .rs2(rs2),
    .set_busy(set_busy),
    .busy_addr(busy_addr),
    .issue(issue_bus.sender)
  );

  reservation_station reservation_station_i (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .issue(issue_bus.receiver),
    .exec(exec_bus.sender)
  );

  alu alu_i (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .result_ack(result_ack),
    .exec(exec_bus.receiver),
    .result_req(result_req),
    .result_data(result_data),
    .result_rd(result_rd),
    .wb_en(wb_en),
    .wb_addr(wb_addr),
    .wb_data(wb_data)
  );

endmodule

// File: testbench/core_tb.sv
module core_tb import core_pkg::*; ();

  localparam int prog_len = 300;
  localparam int preload_len = reg_count - 1;  // x1..x31
  localparam int cycles_per_inst = 400;
  localparam int clk_period = 100;

  logic clk_100mhz;
  logic rst;
  logic inst_req;
  logic [xlen-1:0] instruction;
  logic result_ack;
  logic inst_ack;
  logic result_req;
  logic [xlen-1:0] result_data;
  logic [reg_addr_w-1:0] result_rd;

  // reference model state
  logic [xlen-1:0] model_regs [reg_count];
  logic [reg_addr_w-1:0] exp_rd_q [$];
  logic [xlen-1:0] exp_data_q [$];
  logic [reg_addr_w-1:0] last_rd;

  int errors = 0;
  int checks = 0;
  int alu_sent = 0;
  int dropped_sent = 0;
  int results_seen = 0;

  core_top core_top_i (
    .clk_100mhz(clk_100mhz),
    .rst(rst),
    .inst_req(inst_req),
    .instruction(instruction),
    .result_ack(result_ack),
    .inst_ack(inst_ack),
    .result_req(result_req),
    .result_data(result_data),
    .result_rd(result_rd)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #(clk_period / 2) clk_100mhz = ~clk_100mhz;
  end

  task automatic check_value(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [xlen-1:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] funct3,
                                            input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, opcode_op};
  endfunction

  function automatic logic [xlen-1:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] funct3, input logic [4:0] rd);
    return {imm, rs1, funct3, rd, opcode_opimm};
  endfunction

  // load, store, branch, jal, lui, system
  function automatic logic [6:0] other_opcode(input int sel);
    case (sel)
      0: return 7'b0000011;
      1: return 7'b0100011;
      2: return 7'b1100011;
      3: return 7'b1101111;
      4: return 7'b0110111;
      default: return 7'b1110011;
    endcase
  endfunction

  // executes one instruction in program order, queues the expected result
  task automatic model_step(input logic [xlen-1:0] inst);
    logic is_imm;
    logic [2:0] f3;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] r;
    logic [4:0] sh;
    if (inst[6:0] != opcode_op && inst[6:0] != opcode_opimm) begin
      dropped_sent++;  // no result for these
    end else begin
      is_imm = inst[6:0] == opcode_opimm;
      f3 = inst[14:12];
      a = model_regs[inst[19:15]];
      b = is_imm ? {{20{inst[31]}}, inst[31:20]} : model_regs[inst[24:20]];
      sh = b[4:0];  // shamt lives in the low immediate bits for OP-IMM
      case (f3)
        3'd0: r = (inst[30] && !is_imm) ? a - b : a + b;
        3'd1: r = a << sh;
        3'd2: r = {31'b0, $signed(a) < $signed(b)};
        3'd3: r = {31'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
          if (inst[30]) r = $signed(a) >>> sh;
          else r = a >> sh;
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
      exp_rd_q.push_back(inst[11:7]);
      exp_data_q.push_back(r);
      if (inst[11:7] != 5'd0) model_regs[inst[11:7]] = r;  // x0 stays zero
      alu_sent++;
    end
  endtask

  task automatic make_inst(input int idx, output logic [xlen-1:0] inst);
    int kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    kind = $urandom_range(9, 0);
    rd = 5'($urandom_range(31, 0));
    rs1 = 5'($urandom_range(31, 0));
    rs2 = 5'($urandom_range(31, 0));
    f3 = 3'($urandom_range(7, 0));
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0) == 1) ? 7'b0100000 : 7'b0;
    imm = 12'($urandom);
    if (idx < preload_len) begin
      rd = 5'(idx + 1);
      inst = enc_i(imm, 5'd0, 3'd0, rd);  // addi from x0
    end else if (kind <= 3) begin
      inst = enc_r(f7, rs2, rs1, f3, rd);
    end else if (kind <= 5) begin
      if (f3 == 3'd1 || f3 == 3'd5) imm = {f7, imm[4:0]};
      else if (kind == 5) imm[11] = 1'b1;  // force a negative immediate
      inst = enc_i(imm, rs1, f3, rd);
    end else if (kind <= 7) begin
      // chain on the previous destination
      rs1 = last_rd;
      if (kind == 7) rs2 = last_rd;
      inst = enc_r(f7, rs2, rs1, f3, rd);
    end else if (kind == 8) begin
      rd = 5'd0;
      rs2 = 5'd0;  // reads x0 after earlier writes to it
      inst = enc_r(f7, rs2, rs1, f3, rd);
    end else begin
      inst = {25'($urandom), other_opcode($urandom_range(5, 0))};
    end
    if (inst[6:0] == opcode_op || inst[6:0] == opcode_opimm) last_rd = rd;
  endtask

  // four-phase on the input port, driven on falling edges
  task automatic send_inst(input logic [xlen-1:0] inst);
    instruction = inst;
    inst_req = 1'b1;
    model_step(inst);
    do @(negedge clk_100mhz); while (inst_ack !== 1'b1);
    inst_req = 1'b0;
    do @(negedge clk_100mhz); while (inst_ack !== 1'b0);
  endtask

  task automatic check_result();
    logic [reg_addr_w-1:0] rd_exp;
    logic [xlen-1:0] data_exp;
    results_seen++;
    if (exp_rd_q.size() == 0) begin
      errors++;
      $display("result port offered rd %0d data %h while no result was expected",
               result_rd, result_data);
    end else begin
      rd_exp = exp_rd_q.pop_front();
      data_exp = exp_data_q.pop_front();
      check_value($sformatf("result %0d rd", results_seen), xlen'(rd_exp), xlen'(result_rd));
      check_value($sformatf("result %0d data", results_seen), data_exp, result_data);
    end
  endtask

  // retire side, random back-pressure
  initial begin
    int delay;
    result_ack = 1'b0;
    forever begin
      @(negedge clk_100mhz);
      if (result_req === 1'b1) begin
        delay = $urandom_range(6, 0);
        repeat (delay) @(negedge clk_100mhz);
        check_result();
        result_ack = 1'b1;
        do @(negedge clk_100mhz); while (result_req !== 1'b0);
        result_ack = 1'b0;
      end
    end
  end

  initial begin
    logic [xlen-1:0] inst;
    void'($urandom(64));
    rst = 1'b1;
    inst_req = 1'b0;
    instruction = '0;
    last_rd = '0;
    for (int i = 0; i < reg_count; i++) model_regs[i] = '0;
    repeat (16) @(posedge clk_100mhz);
    @(negedge clk_100mhz);
    rst = 1'b0;

    for (int i = 0; i < prog_len; i++) begin
      make_inst(i, inst);
      send_inst(inst);
      repeat ($urandom_range(3, 0)) @(negedge clk_100mhz);  // idle gap
    end

    while (exp_rd_q.size() != 0) @(negedge clk_100mhz);
    repeat (50) @(negedge clk_100mhz);  // room for a stray extra result
    check_value("result count", xlen'(alu_sent), xlen'(results_seen));

    $display("checks %0d, errors %0d, alu instructions %0d, dropped %0d",
             checks, errors, alu_sent, dropped_sent);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (16 + prog_len * cycles_per_inst) @(posedge clk_100mhz);
    $display("timeout, the program did not retire in %0d cycles, errors %0d",
             prog_len * cycles_per_inst, errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: list.f
source/core_pkg.sv
source/stage_if.sv
source/instruction_queue.sv
source/decoder.sv
source/register_file.sv
source/issue_unit.sv
source/reservation_station.sv
source/alu.sv
source/core_top.sv
testbench/core_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide on the log contents
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module core_tb -f list.f -o core_sim &&
  ./obj_dir/core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
